// ==== hw/fc_pkg.sv ====
// Widths are fixed for a 32-bit core; IRQ_W must equal DATA_W for the register map to hold
package fc_pkg;

    // Bus widths on both the OBI and PULP sides
    parameter int ADDR_W = 32;
    parameter int DATA_W = 32;
    parameter int BE_W   = 4;

    // Interrupt vector and ID widths
    parameter int IRQ_W    = 32;
    parameter int IRQ_ID_W = 5;

    // Event IDs coming in through the FIFO
    parameter int EVENT_ID_W = 8;

    // Line owned by the event FIFO, not by interrupts_i
    parameter int FIFO_IRQ_LINE = 26;

    // Wishbone word address for four registers
    parameter int WB_ADR_W = 2;

    // Register word addresses
    typedef enum logic [WB_ADR_W-1:0] {
        REG_MASK  = 2'd0,   // Read/write enable mask
        REG_PEND  = 2'd1,   // Read pending, write 1 to clear
        REG_EVENT = 2'd2,   // Read pops the event FIFO
        REG_FETCH = 2'd3    // Bit 0 gates fetch enable
    } eu_reg_e;

    // Adapter states
    typedef enum logic {
        ST_IDLE        = 1'b0,
        ST_WAIT_RVALID = 1'b1
    } adapter_state_e;

endpackage

// ==== hw/obi_pulp_adapter.sv ====
// One outstanding L2 access at a time; assumes rvalid comes at least one cycle after gnt
module obi_pulp_adapter (
    input  logic clk_i,
    input  logic reset_i,
    input  logic core_req_i,
    input  logic mem_gnt_i,
    input  logic mem_rvalid_i,
    output logic mem_req_o
);

    // Outstanding-access tracker
    fc_pkg::adapter_state_e state_q;
    fc_pkg::adapter_state_e state_d;

    // Request passes through only while nothing is in flight
    assign mem_req_o = core_req_i && (state_q == fc_pkg::ST_IDLE);

    // Next-state logic
    always_comb begin
        state_d = state_q;
        case (state_q)
            fc_pkg::ST_IDLE: begin
                // Granted access, now waiting for the response
                if (mem_req_o && mem_gnt_i) begin
                    state_d = fc_pkg::ST_WAIT_RVALID;
                end
            end
            fc_pkg::ST_WAIT_RVALID: begin
                // Response back, next request allowed on the following cycle
                if (mem_rvalid_i) begin
                    state_d = fc_pkg::ST_IDLE;
                end
            end
            default: begin
                state_d = fc_pkg::ST_IDLE;
            end
        endcase
    end

    // State register
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q <= fc_pkg::ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

endmodule

// ==== hw/event_fifo.sv ====
// Push into a full FIFO is dropped, pop from an empty one is ignored; head_o is valid only when not empty
module event_fifo #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic                          clk_i,
    input  logic                          reset_i,
    input  logic                          push_i,
    input  logic                          pop_i,
    input  logic [fc_pkg::EVENT_ID_W-1:0] push_data_i,
    output logic                          fulln_o,
    output logic                          not_empty_o,
    output logic [fc_pkg::EVENT_ID_W-1:0] head_o
);

    // Pointer needs at least one bit even for depth 1
    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    logic [fc_pkg::EVENT_ID_W-1:0] mem_q [FIFO_DEPTH];
    logic [PTR_W-1:0]              wr_ptr_q;
    logic [PTR_W-1:0]              rd_ptr_q;
    logic [CNT_W-1:0]              count_q;
    logic                          push_ok;
    logic                          pop_ok;

    // Status flags from the count
    assign fulln_o     = (count_q != CNT_W'(FIFO_DEPTH));
    assign not_empty_o = (count_q != '0);
    assign head_o      = mem_q[rd_ptr_q];

    // Qualified push and pop
    assign push_ok = push_i && fulln_o;
    assign pop_ok  = pop_i && not_empty_o;

    // Storage, written only on an accepted push
    always_ff @(posedge clk_i) begin
        if (push_ok) begin
            mem_q[wr_ptr_q] <= push_data_i;
        end
    end

    // Pointers wrap at FIFO_DEPTH, not at a power of two
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push_ok) begin
                wr_ptr_q <= (wr_ptr_q == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (pop_ok) begin
                rd_ptr_q <= (rd_ptr_q == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            // Simultaneous push and pop leave the count alone
            if (push_ok && !pop_ok) begin
                count_q <= count_q + 1'b1;
            end else if (pop_ok && !push_ok) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

endmodule

// ==== hw/eu_wb_regs.sv ====
// Wishbone classic, no wb_sel; writes and pops act at the edge where wb_ack_o rises
module eu_wb_regs (
    input  logic                          clk_i,
    input  logic                          reset_i,
    input  logic                          wb_cyc_i,
    input  logic                          wb_stb_i,
    input  logic                          wb_we_i,
    input  logic [fc_pkg::WB_ADR_W-1:0]   wb_adr_i,
    input  logic [fc_pkg::DATA_W-1:0]     wb_dat_i,
    input  logic [fc_pkg::IRQ_W-1:0]      pending_i,
    input  logic                          fifo_not_empty_i,
    input  logic [fc_pkg::EVENT_ID_W-1:0] fifo_head_i,
    input  logic                          fetch_en_i,
    output logic [fc_pkg::DATA_W-1:0]     wb_dat_o,
    output logic                          wb_ack_o,
    output logic [fc_pkg::IRQ_W-1:0]      mask_o,
    output logic [fc_pkg::IRQ_W-1:0]      pend_clr_o,
    output logic                          fifo_pop_o,
    output logic                          core_fetch_en_o
);

    logic                         access;
    logic                         wr_en;
    logic                         rd_en;
    fc_pkg::eu_reg_e              reg_sel;
    logic [fc_pkg::IRQ_W-1:0]     mask_q;
    logic                         fetch_q;
    logic                         ack_q;
    logic [fc_pkg::DATA_W-1:0]    rdata_d;
    logic [fc_pkg::DATA_W-1:0]    rdata_q;

    // ************************************************
    // Access decode
    // ************************************************

    // No new access in the ack cycle, so ack never repeats
    assign access  = wb_cyc_i && wb_stb_i && !ack_q;
    assign wr_en   = access && wb_we_i;
    assign rd_en   = access && !wb_we_i;
    assign reg_sel = fc_pkg::eu_reg_e'(wb_adr_i);

    // Single-cycle strobes to the arbiter and the FIFO
    assign pend_clr_o = (wr_en && reg_sel == fc_pkg::REG_PEND) ? wb_dat_i : '0;
    assign fifo_pop_o = rd_en && (reg_sel == fc_pkg::REG_EVENT);

    // Read mux
    always_comb begin
        rdata_d = '0;
        case (reg_sel)
            fc_pkg::REG_MASK:  rdata_d = mask_q;
            fc_pkg::REG_PEND:  rdata_d = pending_i;
            fc_pkg::REG_EVENT: begin
                // Valid flag in bit 31, ID in the low byte
                if (fifo_not_empty_i) begin
                    rdata_d = {1'b1, {(fc_pkg::DATA_W - 1 - fc_pkg::EVENT_ID_W){1'b0}},
                               fifo_head_i};
                end
            end
            fc_pkg::REG_FETCH: rdata_d = {{(fc_pkg::DATA_W - 1){1'b0}}, fetch_q};
            default:           rdata_d = '0;
        endcase
    end

    // ************************************************
    // Registers
    // ************************************************

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            mask_q  <= '0;
            fetch_q <= 1'b1;
            ack_q   <= 1'b0;
        end else begin
            ack_q <= access;
            if (wr_en && reg_sel == fc_pkg::REG_MASK) begin
                mask_q <= wb_dat_i;
            end
            if (wr_en && reg_sel == fc_pkg::REG_FETCH) begin
                fetch_q <= wb_dat_i[0];
            end
        end
    end

    // Read data held until the next read
    always_ff @(posedge clk_i) begin
        if (rd_en) begin
            rdata_q <= rdata_d;
        end
    end

    assign wb_ack_o        = ack_q;
    assign wb_dat_o        = rdata_q;
    assign mask_o          = mask_q;
    // Software gate on the external fetch enable
    assign core_fetch_en_o = fetch_q && fetch_en_i;

endmodule

// ==== hw/irq_arbiter.sv ====
// interrupts_i bit FIFO_IRQ_LINE is ignored; that line is owned by the event FIFO
module irq_arbiter (
    input  logic                        clk_i,
    input  logic                        reset_i,
    input  logic [fc_pkg::IRQ_W-1:0]    irq_lines_i,
    input  logic [fc_pkg::IRQ_W-1:0]    mask_i,
    input  logic [fc_pkg::IRQ_W-1:0]    pend_clr_i,
    input  logic                        fifo_not_empty_i,
    input  logic                        core_irq_ack_i,
    input  logic [fc_pkg::IRQ_ID_W-1:0] core_irq_ack_id_i,
    output logic [fc_pkg::IRQ_W-1:0]    pending_o,
    output logic                        core_irq_req_o,
    output logic [fc_pkg::IRQ_ID_W-1:0] core_irq_id_o,
    output logic [fc_pkg::IRQ_W-1:0]    core_irq_x_o
);

    localparam logic [fc_pkg::IRQ_W-1:0] FIFO_BIT = fc_pkg::IRQ_W'(1) << fc_pkg::FIFO_IRQ_LINE;

    logic [fc_pkg::IRQ_W-1:0] pend_q;
    logic [fc_pkg::IRQ_W-1:0] ack_clr;
    logic [fc_pkg::IRQ_W-1:0] clr;
    logic [fc_pkg::IRQ_W-1:0] active;

    // Core acknowledge as a one-hot clear
    always_comb begin
        ack_clr = '0;
        if (core_irq_ack_i) begin
            ack_clr[core_irq_ack_id_i] = 1'b1;
        end
    end

    assign clr = pend_clr_i | ack_clr;

    // Pending register
    // Clear first, then OR the sampled lines so a line still high stays set
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            pend_q <= '0;
        end else begin
            pend_q <= ((pend_q & ~clr) | irq_lines_i) & ~FIFO_BIT;
        end
    end

    // FIFO line follows the FIFO level directly
    assign pending_o = pend_q | (fifo_not_empty_i ? FIFO_BIT : '0);
    assign active    = pending_o & mask_i;

    // Highest enabled line wins, later iterations overwrite earlier ones
    always_comb begin
        core_irq_req_o = 1'b0;
        core_irq_id_o  = '0;
        for (int unsigned i = 0; i < fc_pkg::IRQ_W; i++) begin
            if (active[i]) begin
                core_irq_req_o = 1'b1;
                core_irq_id_o  = i[fc_pkg::IRQ_ID_W-1:0];
            end
        end
    end

    // ID expanded back to a line vector
    always_comb begin
        core_irq_x_o = '0;
        if (core_irq_req_o) begin
            core_irq_x_o[core_irq_id_o] = 1'b1;
        end
    end

endmodule

// ==== hw/fc_subsystem.sv ====
// Core sits outside; core bus fields must hold from req to gnt, and events on a full FIFO are lost
module fc_subsystem #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic                          clk_i,
    input  logic                          reset_i,
    input  logic                          fetch_en_i,

    // Core instruction side, OBI
    input  logic                          core_instr_req_i,
    input  logic [fc_pkg::ADDR_W-1:0]     core_instr_addr_i,
    output logic                          core_instr_gnt_o,
    output logic                          core_instr_rvalid_o,
    output logic [fc_pkg::DATA_W-1:0]     core_instr_rdata_o,
    output logic                          core_instr_err_o,

    // Core data side, OBI
    input  logic                          core_data_req_i,
    input  logic                          core_data_we_i,
    input  logic [fc_pkg::BE_W-1:0]       core_data_be_i,
    input  logic [fc_pkg::ADDR_W-1:0]     core_data_addr_i,
    input  logic [fc_pkg::DATA_W-1:0]     core_data_wdata_i,
    output logic                          core_data_gnt_o,
    output logic                          core_data_rvalid_o,
    output logic [fc_pkg::DATA_W-1:0]     core_data_rdata_o,
    output logic                          core_data_err_o,

    // L2 instruction bus, PULP
    output logic                          l2_instr_req_o,
    output logic [fc_pkg::ADDR_W-1:0]     l2_instr_add_o,
    input  logic                          l2_instr_gnt_i,
    input  logic                          l2_instr_rvalid_i,
    input  logic [fc_pkg::DATA_W-1:0]     l2_instr_rdata_i,
    input  logic                          l2_instr_err_i,

    // L2 data bus, PULP
    output logic                          l2_data_req_o,
    output logic [fc_pkg::ADDR_W-1:0]     l2_data_add_o,
    output logic                          l2_data_wen_o,
    output logic [fc_pkg::DATA_W-1:0]     l2_data_wdata_o,
    output logic [fc_pkg::BE_W-1:0]       l2_data_be_o,
    input  logic                          l2_data_gnt_i,
    input  logic                          l2_data_rvalid_i,
    input  logic [fc_pkg::DATA_W-1:0]     l2_data_rdata_i,
    input  logic                          l2_data_err_i,

    // Interrupts and events
    input  logic [fc_pkg::IRQ_W-1:0]      interrupts_i,
    input  logic                          event_fifo_valid_i,
    input  logic [fc_pkg::EVENT_ID_W-1:0] event_fifo_data_i,
    output logic                          event_fifo_fulln_o,
    input  logic                          core_irq_ack_i,
    input  logic [fc_pkg::IRQ_ID_W-1:0]   core_irq_ack_id_i,
    output logic                          core_irq_req_o,
    output logic [fc_pkg::IRQ_ID_W-1:0]   core_irq_id_o,
    output logic [fc_pkg::IRQ_W-1:0]      core_irq_x_o,

    // Configuration, Wishbone classic
    input  logic                          wb_cyc_i,
    input  logic                          wb_stb_i,
    input  logic                          wb_we_i,
    input  logic [fc_pkg::WB_ADR_W-1:0]   wb_adr_i,
    input  logic [fc_pkg::DATA_W-1:0]     wb_dat_i,
    output logic [fc_pkg::DATA_W-1:0]     wb_dat_o,
    output logic                          wb_ack_o,
    output logic                          core_fetch_en_o
);

    logic                          fifo_not_empty;
    logic                          fifo_pop;
    logic [fc_pkg::EVENT_ID_W-1:0] fifo_head;
    logic [fc_pkg::IRQ_W-1:0]      mask;
    logic [fc_pkg::IRQ_W-1:0]      pend_clr;
    logic [fc_pkg::IRQ_W-1:0]      pending;

    // ************************************************
    // Instruction bus
    // ************************************************

    assign l2_instr_add_o      = core_instr_addr_i;
    assign core_instr_gnt_o    = l2_instr_gnt_i;
    assign core_instr_rvalid_o = l2_instr_rvalid_i;
    assign core_instr_rdata_o  = l2_instr_rdata_i;
    assign core_instr_err_o    = l2_instr_err_i;

    obi_pulp_adapter i_adapter_instr (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .core_req_i   (core_instr_req_i),
        .mem_gnt_i    (l2_instr_gnt_i),
        .mem_rvalid_i (l2_instr_rvalid_i),
        .mem_req_o    (l2_instr_req_o)
    );

    // ************************************************
    // Data bus
    // ************************************************

    assign l2_data_add_o      = core_data_addr_i;
    // PULP wen is active low for writes
    assign l2_data_wen_o      = ~core_data_we_i;
    assign l2_data_wdata_o    = core_data_wdata_i;
    assign l2_data_be_o       = core_data_be_i;
    assign core_data_gnt_o    = l2_data_gnt_i;
    assign core_data_rvalid_o = l2_data_rvalid_i;
    assign core_data_rdata_o  = l2_data_rdata_i;
    assign core_data_err_o    = l2_data_err_i;

    obi_pulp_adapter i_adapter_data (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .core_req_i   (core_data_req_i),
        .mem_gnt_i    (l2_data_gnt_i),
        .mem_rvalid_i (l2_data_rvalid_i),
        .mem_req_o    (l2_data_req_o)
    );

    // ************************************************
    // Event unit
    // ************************************************

    // FIFO drops the push itself when full
    event_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) i_event_fifo (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .push_i      (event_fifo_valid_i),
        .pop_i       (fifo_pop),
        .push_data_i (event_fifo_data_i),
        .fulln_o     (event_fifo_fulln_o),
        .not_empty_o (fifo_not_empty),
        .head_o      (fifo_head)
    );

    eu_wb_regs i_eu_wb_regs (
        .clk_i            (clk_i),
        .reset_i          (reset_i),
        .wb_cyc_i         (wb_cyc_i),
        .wb_stb_i         (wb_stb_i),
        .wb_we_i          (wb_we_i),
        .wb_adr_i         (wb_adr_i),
        .wb_dat_i         (wb_dat_i),
        .pending_i        (pending),
        .fifo_not_empty_i (fifo_not_empty),
        .fifo_head_i      (fifo_head),
        .fetch_en_i       (fetch_en_i),
        .wb_dat_o         (wb_dat_o),
        .wb_ack_o         (wb_ack_o),
        .mask_o           (mask),
        .pend_clr_o       (pend_clr),
        .fifo_pop_o       (fifo_pop),
        .core_fetch_en_o  (core_fetch_en_o)
    );

    irq_arbiter i_irq_arbiter (
        .clk_i             (clk_i),
        .reset_i           (reset_i),
        .irq_lines_i       (interrupts_i),
        .mask_i            (mask),
        .pend_clr_i        (pend_clr),
        .fifo_not_empty_i  (fifo_not_empty),
        .core_irq_ack_i    (core_irq_ack_i),
        .core_irq_ack_id_i (core_irq_ack_id_i),
        .pending_o         (pending),
        .core_irq_req_o    (core_irq_req_o),
        .core_irq_id_o     (core_irq_id_o),
        .core_irq_x_o      (core_irq_x_o)
    );

endmodule

// ==== sim/fc_subsystem_chk.sv ====
// Protocol assertions for fc_subsystem; attached by bind, needs the internal mask net
module fc_subsystem_chk (
    input logic                        clk_i,
    input logic                        reset_i,
    input logic                        l2_instr_req_o,
    input logic                        l2_instr_gnt_i,
    input logic                        l2_instr_rvalid_i,
    input logic                        l2_data_req_o,
    input logic                        l2_data_gnt_i,
    input logic                        l2_data_rvalid_i,
    input logic                        wb_ack_o,
    input logic                        core_irq_req_o,
    input logic [fc_pkg::IRQ_ID_W-1:0] core_irq_id_o,
    input logic [fc_pkg::IRQ_W-1:0]    core_irq_x_o,
    input logic [fc_pkg::IRQ_W-1:0]    mask_i
);

    logic instr_busy_q;
    logic data_busy_q;

    // Outstanding access trackers, set on grant, cleared on response
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            instr_busy_q <= 1'b0;
            data_busy_q  <= 1'b0;
        end else begin
            if (l2_instr_req_o && l2_instr_gnt_i) begin
                instr_busy_q <= 1'b1;
            end else if (l2_instr_rvalid_i) begin
                instr_busy_q <= 1'b0;
            end
            if (l2_data_req_o && l2_data_gnt_i) begin
                data_busy_q <= 1'b1;
            end else if (l2_data_rvalid_i) begin
                data_busy_q <= 1'b0;
            end
        end
    end

    // No second request while a response is still due
    a_instr_one_out: assert property (@(posedge clk_i) disable iff (reset_i)
        instr_busy_q |-> !l2_instr_req_o) else $error("instr req while busy");
    a_data_one_out: assert property (@(posedge clk_i) disable iff (reset_i)
        data_busy_q |-> !l2_data_req_o) else $error("data req while busy");

    // Single-cycle ack
    a_ack_single: assert property (@(posedge clk_i) disable iff (reset_i)
        wb_ack_o |=> !wb_ack_o) else $error("wb ack on two cycles");

    a_irq_onehot: assert property (@(posedge clk_i) disable iff (reset_i)
        $onehot0(core_irq_x_o)) else $error("irq vector not one-hot");

    // Only enabled lines may reach the core
    a_irq_masked: assert property (@(posedge clk_i) disable iff (reset_i)
        core_irq_req_o |-> mask_i[core_irq_id_o]) else $error("irq of masked line");

endmodule

// ==== sim/tb_fc_subsystem.sv ====
// Self-checking testbench; fixed seed, FIFO depth 4, run limited to 4000 cycles
module tb_fc_subsystem;

    localparam int DEPTH  = 4;
    localparam int N_BUS  = 200;
    localparam int LIMIT  = 4000;
    localparam logic [31:0] BIT26 = 32'h1 << fc_pkg::FIFO_IRQ_LINE;

    logic clk_i, reset_i, fetch_en_i;
    logic core_instr_req_i, core_data_req_i, core_data_we_i;
    logic [31:0] core_instr_addr_i, core_data_addr_i, core_data_wdata_i;
    logic [3:0] core_data_be_i;
    logic l2_instr_gnt_i, l2_instr_rvalid_i, l2_instr_err_i;
    logic l2_data_gnt_i, l2_data_rvalid_i, l2_data_err_i;
    logic [31:0] l2_instr_rdata_i, l2_data_rdata_i, interrupts_i;
    logic event_fifo_valid_i, core_irq_ack_i;
    logic [7:0] event_fifo_data_i;
    logic [4:0] core_irq_ack_id_i;
    logic wb_cyc_i, wb_stb_i, wb_we_i;
    logic [1:0] wb_adr_i;
    logic [31:0] wb_dat_i;
    logic core_instr_gnt_o, core_instr_rvalid_o, core_instr_err_o;
    logic core_data_gnt_o, core_data_rvalid_o, core_data_err_o;
    logic [31:0] core_instr_rdata_o, core_data_rdata_o;
    logic l2_instr_req_o, l2_data_req_o, l2_data_wen_o;
    logic [31:0] l2_instr_add_o, l2_data_add_o, l2_data_wdata_o;
    logic [3:0] l2_data_be_o;
    logic event_fifo_fulln_o, core_irq_req_o, wb_ack_o, core_fetch_en_o;
    logic [4:0] core_irq_id_o;
    logic [31:0] core_irq_x_o, wb_dat_o;

    integer seed = 32'h876a076a;
    int cycles = 0;

    // Interrupt reference model state
    logic [31:0] model_pend, model_mask, irq_prev;
    logic        ack_prev, exp_req;
    logic [4:0]  ack_id_prev, exp_id;

    fc_subsystem #(.FIFO_DEPTH(DEPTH)) DUT (.*);

    bind fc_subsystem fc_subsystem_chk i_chk (
        .clk_i(clk_i), .reset_i(reset_i),
        .l2_instr_req_o(l2_instr_req_o), .l2_instr_gnt_i(l2_instr_gnt_i),
        .l2_instr_rvalid_i(l2_instr_rvalid_i),
        .l2_data_req_o(l2_data_req_o), .l2_data_gnt_i(l2_data_gnt_i),
        .l2_data_rvalid_i(l2_data_rvalid_i), .wb_ack_o(wb_ack_o),
        .core_irq_req_o(core_irq_req_o), .core_irq_id_o(core_irq_id_o),
        .core_irq_x_o(core_irq_x_o), .mask_i(mask)
    );

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    // Run limit
    always @(posedge clk_i) begin
        cycles <= cycles + 1;
        if (cycles >= LIMIT) begin
            $display("Test failed");
            $fatal(1, "run did not finish within %0d cycles", LIMIT);
        end
    end

    task automatic check(input logic [31:0] got, input logic [31:0] exp, input string msg);
        if (got !== exp) begin
            $display("error at %0t: %s, got %h expected %h", $time, msg, got, exp);
            $display("Test failed");
            $fatal(1, "value mismatch");
        end
    endtask

    function automatic logic [4:0] highest_line(input logic [31:0] v);
        logic [4:0] id;
        id = '0;
        for (int i = 0; i < 32; i++) begin
            if (v[i]) begin
                id = 5'(i);
            end
        end
        return id;
    endfunction

    // ************************************************
    // Wishbone master
    // ************************************************

    task automatic wb_access(input logic we, input logic [1:0] adr, input logic [31:0] dat,
                             output logic [31:0] rdata);
        @(posedge clk_i);
        wb_cyc_i <= 1'b1;
        wb_stb_i <= 1'b1;
        wb_we_i  <= we;
        wb_adr_i <= adr;
        wb_dat_i <= dat;
        do begin
            @(negedge clk_i);
        end while (!wb_ack_o);
        rdata = wb_dat_o;
        @(posedge clk_i);
        wb_cyc_i <= 1'b0;
        wb_stb_i <= 1'b0;
    endtask

    // ************************************************
    // Core and L2 models on one bus
    // ************************************************

    task automatic run_bus(input bit sel);
        int          issued, granted, done, cnt;
        logic        req_l2, hs, core_req, start, gnt, rv, err;
        logic [31:0] sent;
        issued = 0;
        granted = 0;
        done = 0;
        cnt = 0;
        core_req = 1'b0;
        gnt = 1'b0;
        rv = 1'b0;
        err = 1'b0;
        sent = '0;
        while (done < N_BUS) begin
            @(negedge clk_i);
            req_l2 = sel ? l2_data_req_o : l2_instr_req_o;
            hs = req_l2 && (sel ? l2_data_gnt_i : l2_instr_gnt_i);
            if (hs) begin
                granted++;
                cnt = 1 + ($unsigned($random(seed)) % 3);
            end
            if (sel ? l2_data_rvalid_i : l2_instr_rvalid_i) begin
                check(sel ? core_data_rdata_o : core_instr_rdata_o, sent, "response data");
                done++;
            end
            // Fields and response flags pass straight through
            if (sel) begin
                check(32'(core_data_gnt_o), 32'(gnt), "data gnt");
                check(32'(core_data_rvalid_o), 32'(rv), "data rvalid");
                check(32'(core_data_err_o), 32'(err), "data err");
                check(l2_data_add_o, core_data_addr_i, "data address");
                check(l2_data_wdata_o, core_data_wdata_i, "data write data");
                check(32'(l2_data_be_o), 32'(core_data_be_i), "data byte enable");
            end else begin
                check(32'(core_instr_gnt_o), 32'(gnt), "instr gnt");
                check(32'(core_instr_rvalid_o), 32'(rv), "instr rvalid");
                check(32'(core_instr_err_o), 32'(err), "instr err");
                check(l2_instr_add_o, core_instr_addr_i, "instr address");
            end
            check(32'(l2_data_wen_o), 32'(!core_data_we_i), "data wen");
            @(posedge clk_i);
            // Core holds req until granted
            start = 1'b0;
            if (hs || !core_req) begin
                start = (issued < N_BUS) && (($random(seed) & 3) != 0);
                core_req = start;
            end
            if (start) begin
                issued++;
            end
            // Memory grants only a request that stays up
            gnt = req_l2 && !hs && (($random(seed) & 3) != 0);
            rv = 1'b0;
            if (cnt > 0) begin
                cnt--;
                rv = (cnt == 0);
            end
            if (rv) begin
                sent = $random(seed);
            end
            // Error flag only rides along with a response
            err = rv && (($random(seed) & 1) != 0);
            if (sel) begin
                core_data_req_i  <= core_req;
                l2_data_gnt_i    <= gnt;
                l2_data_rvalid_i <= rv;
                l2_data_rdata_i  <= sent;
                l2_data_err_i    <= err;
                if (start) begin
                    core_data_we_i    <= 1'($random(seed));
                    core_data_addr_i  <= $random(seed);
                    core_data_wdata_i <= $random(seed);
                    core_data_be_i    <= 4'($random(seed));
                end
            end else begin
                core_instr_req_i  <= core_req;
                l2_instr_gnt_i    <= gnt;
                l2_instr_rvalid_i <= rv;
                l2_instr_rdata_i  <= sent;
                l2_instr_err_i    <= err;
                if (start) begin
                    core_instr_addr_i <= $random(seed);
                end
            end
        end
        check(granted, issued, "grants against core requests");
    endtask

    // ************************************************
    // Interrupt stepping with the reference model
    // ************************************************

    // Lines driven now are sampled at the next edge
    task automatic irq_step(input logic [31:0] lines, input logic ack, input logic [4:0] ack_id);
        logic [31:0] clr, active;
        @(posedge clk_i);
        clr = ack_prev ? (32'h1 << ack_id_prev) : '0;
        model_pend = ((model_pend & ~clr) | irq_prev) & ~BIT26;
        interrupts_i      <= lines;
        core_irq_ack_i    <= ack;
        core_irq_ack_id_i <= ack_id;
        irq_prev = lines;
        ack_prev = ack;
        ack_id_prev = ack_id;
        @(negedge clk_i);
        active = model_pend & model_mask;
        exp_req = (active != 0);
        exp_id = highest_line(active);
        check(32'(core_irq_req_o), 32'(exp_req), "irq req");
        check(32'(core_irq_id_o), 32'(exp_id), "irq id");
        check(core_irq_x_o, exp_req ? (32'h1 << exp_id) : '0, "irq one-hot");
    endtask

    initial begin
        logic [31:0] rd, dat;
        logic [7:0]  id;
        logic        fetch;
        logic [7:0]  fifo_q[$];
        int          extra;
        fetch_en_i = 1'b1;
        core_instr_req_i = 1'b0;
        core_instr_addr_i = '0;
        core_data_req_i = 1'b0;
        core_data_we_i = 1'b0;
        core_data_be_i = '0;
        core_data_addr_i = '0;
        core_data_wdata_i = '0;
        l2_instr_gnt_i = 1'b0;
        l2_instr_rvalid_i = 1'b0;
        l2_instr_rdata_i = '0;
        l2_instr_err_i = 1'b0;
        l2_data_gnt_i = 1'b0;
        l2_data_rvalid_i = 1'b0;
        l2_data_rdata_i = '0;
        l2_data_err_i = 1'b0;
        interrupts_i = '0;
        event_fifo_valid_i = 1'b0;
        event_fifo_data_i = '0;
        core_irq_ack_i = 1'b0;
        core_irq_ack_id_i = '0;
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
        wb_we_i = 1'b0;
        wb_adr_i = '0;
        wb_dat_i = '0;
        model_pend = '0;
        irq_prev = '0;
        ack_prev = 1'b0;
        ack_id_prev = '0;
        exp_req = 1'b0;
        exp_id = '0;
        reset_i = 1'b1;
        repeat (8) @(posedge clk_i);
        reset_i <= 1'b0;

        // Bus adapters one bus after the other
        run_bus(1'b0);
        run_bus(1'b1);

        // Register readback and fetch gating
        fetch = 1'b1;
        for (int i = 0; i < 20; i++) begin
            dat = $random(seed);
            if (i % 2 == 0) begin
                wb_access(1'b1, fc_pkg::REG_MASK, dat, rd);
                wb_access(1'b0, fc_pkg::REG_MASK, '0, rd);
                check(rd, dat, "mask readback");
            end else begin
                fetch = dat[0];
                @(posedge clk_i);
                fetch_en_i <= 1'($random(seed));
                wb_access(1'b1, fc_pkg::REG_FETCH, dat, rd);
                wb_access(1'b0, fc_pkg::REG_FETCH, '0, rd);
                check(rd, 32'(fetch), "fetch readback");
                check(32'(core_fetch_en_o), 32'(fetch_en_i & fetch), "fetch gating");
            end
        end

        // Priority with a fresh random mask
        model_mask = $random(seed) | $random(seed);
        wb_access(1'b1, fc_pkg::REG_MASK, model_mask, rd);
        for (int i = 0; i < 200; i++) begin
            irq_step($random(seed) & $random(seed) & $random(seed),
                     exp_req && (($random(seed) & 1) != 0), exp_id);
        end

        // Software clear through REG_PEND
        for (int i = 0; i < 6; i++) begin
            irq_step($random(seed) & $random(seed), 1'b0, '0);
            irq_step('0, 1'b0, '0);
            irq_step('0, 1'b0, '0);
            wb_access(1'b0, fc_pkg::REG_PEND, '0, rd);
            check(rd, model_pend, "pending readback");
            dat = $random(seed);
            wb_access(1'b1, fc_pkg::REG_PEND, dat, rd);
            model_pend = model_pend & ~dat;
            wb_access(1'b0, fc_pkg::REG_PEND, '0, rd);
            check(rd, model_pend, "pending after clear");
        end

        // Event FIFO filled past full
        extra = 0;
        while (extra < 3) begin
            id = 8'($random(seed));
            @(posedge clk_i);
            event_fifo_valid_i <= 1'b1;
            event_fifo_data_i  <= id;
            @(negedge clk_i);
            if (event_fifo_fulln_o) begin
                fifo_q.push_back(id);
            end else begin
                extra++;
            end
        end
        @(posedge clk_i);
        event_fifo_valid_i <= 1'b0;
        check(fifo_q.size(), DEPTH, "accepted event count");
        while (fifo_q.size() > 0) begin
            wb_access(1'b0, fc_pkg::REG_PEND, '0, rd);
            check(32'(rd[fc_pkg::FIFO_IRQ_LINE]), 32'h1, "line 26 with data");
            wb_access(1'b0, fc_pkg::REG_EVENT, '0, rd);
            check(rd, {1'b1, 23'b0, fifo_q.pop_front()}, "event pop");
        end
        wb_access(1'b0, fc_pkg::REG_EVENT, '0, rd);
        check(rd, '0, "event pop when empty");
        wb_access(1'b0, fc_pkg::REG_PEND, '0, rd);
        check(32'(rd[fc_pkg::FIFO_IRQ_LINE]), 32'h0, "line 26 when empty");

        $display("Test passed");
        $finish;
    end

endmodule

// ==== files.f ====
hw/fc_pkg.sv
hw/obi_pulp_adapter.sv
hw/event_fifo.sv
hw/eu_wb_regs.sv
hw/irq_arbiter.sv
hw/fc_subsystem.sv
sim/fc_subsystem_chk.sv
sim/tb_fc_subsystem.sv
